//--- src/maze_pkg.sv
`default_nettype none

package maze_pkg;

	// grid geometry, cell address is {y, x}
	localparam int MAZE_DIM    = 16;
	localparam int COORD_W     = 4;
	localparam int CELL_ADDR_W = 8;
	localparam int DIR_W       = 2;

	// stack and path list sizing, pointer has one extra bit to see full
	localparam int STORE_DEPTH = 256;
	localparam int PTR_W       = 9;

	localparam logic [COORD_W-1:0] GOAL_X = 4'd15;
	localparam logic [COORD_W-1:0] GOAL_Y = 4'd15;

	// search order follows the encoding
	typedef enum logic [DIR_W-1:0] {
		dir_north = 2'd0,
		dir_east  = 2'd1,
		dir_south = 2'd2,
		dir_west  = 2'd3
	} dir_e;

endpackage

`default_nettype wire

//--- src/solver_pkg.sv
`default_nettype none

package solver_pkg;

	localparam int STATE_W = 5;

	typedef enum logic [STATE_W-1:0] {
		st_idle              = 5'd0,
		st_init              = 5'd1,
		st_init_search       = 5'd2,
		st_make_wall         = 5'd3,
		st_add_to_stack      = 5'd4,
		st_update_xy         = 5'd5,
		st_check_goal        = 5'd6,
		st_check_wall        = 5'd7,
		st_pop_stack         = 5'd8,
		st_change_dir        = 5'd9,
		st_check_empty_stack = 5'd10,
		st_update_list       = 5'd11,
		st_stack_read        = 5'd12,
		st_done              = 5'd13,
		st_show              = 5'd14,
		st_fail              = 5'd15
	} solver_state_e;

endpackage

`default_nettype wire

//--- src/solver_controller.sv
`timescale 1ns/100ps
`default_nettype none

module solver_controller
	import solver_pkg::*;
(
	input  wire  CLK,
	input  wire  RST,
	input  wire  start,
	input  wire  run,
	input  wire  at_goal,
	input  wire  blocked,
	input  wire  dir_wrap,
	input  wire  stack_empty,
	input  wire  read_last,
	output logic init_pos,
	output logic init_dir,
	output logic mark_cell,
	output logic stack_push,
	output logic step,
	output logic stack_pop,
	output logic dir_next,
	output logic list_push,
	output logic read_start,
	output logic read_step,
	output logic done,
	output logic fail,
	output logic path_valid
);

	solver_state_e state;
	solver_state_e state_nxt;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			state <= st_idle;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:              if (start) state_nxt = st_init;
			st_init:              state_nxt = st_init_search;
			st_init_search:       state_nxt = st_make_wall;
			st_make_wall:         state_nxt = st_add_to_stack;
			st_add_to_stack:      state_nxt = st_update_xy;
			st_update_xy:         state_nxt = st_check_goal;
			st_check_goal:        state_nxt = at_goal ? st_update_list : st_check_wall;
			// a blocked step undoes itself through the stack
			st_check_wall:        state_nxt = blocked ? st_pop_stack : st_init_search;
			st_pop_stack:         state_nxt = st_change_dir;
			st_change_dir:        state_nxt = dir_wrap ? st_check_empty_stack : st_add_to_stack;
			st_check_empty_stack: state_nxt = stack_empty ? st_fail : st_pop_stack;
			st_update_list:       state_nxt = stack_empty ? st_done : st_stack_read;
			st_stack_read:        state_nxt = st_update_list;
			st_done:              if (run) state_nxt = st_show;
			st_show:              if (read_last) state_nxt = st_done;
			st_fail:              state_nxt = st_fail;
			default:              state_nxt = st_idle;
		endcase
	end

	always_comb begin
		init_pos   = 1'b0;
		init_dir   = 1'b0;
		mark_cell  = 1'b0;
		stack_push = 1'b0;
		step       = 1'b0;
		stack_pop  = 1'b0;
		dir_next   = 1'b0;
		list_push  = 1'b0;
		read_start = 1'b0;
		read_step  = 1'b0;
		done       = 1'b0;
		fail       = 1'b0;
		path_valid = 1'b0;
		case (state)
			st_init:         init_pos = 1'b1;
			st_init_search:  init_dir = 1'b1;
			// visited cells look like walls from then on
			st_make_wall:    mark_cell = 1'b1;
			st_add_to_stack: stack_push = 1'b1;
			st_update_xy:    step = 1'b1;
			st_pop_stack:    stack_pop = 1'b1;
			st_change_dir:   dir_next = 1'b1;
			st_update_list:  list_push = 1'b1;
			st_stack_read:   stack_pop = 1'b1;
			st_done: begin
				done       = 1'b1;
				read_start = run;
			end
			st_show: begin
				read_step  = 1'b1;
				path_valid = 1'b1;
			end
			st_fail:         fail = 1'b1;
			default: ;
		endcase
	end

	// fail is terminal and done never follows it
	a_done_fail_excl: assert property (
		@(posedge CLK) disable iff (RST)
		fail |=> fail && !done
	);

	a_found_never_fails: assert property (
		@(posedge CLK) disable iff (RST)
		(done || path_valid) |=> !fail
	);

	// stack is only drained while the path list is built
	a_no_push_in_readout: assert property (
		@(posedge CLK) disable iff (RST)
		(state inside {st_update_list, st_stack_read}) |=> !stack_push
	);

endmodule

`default_nettype wire

//--- src/position_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module position_datapath
	import maze_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     init_pos,
	input  wire                     init_dir,
	input  wire                     step,
	input  wire                     stack_pop,
	input  wire                     dir_next,
	input  wire logic [COORD_W-1:0] pop_x,
	input  wire logic [COORD_W-1:0] pop_y,
	input  wire dir_e               pop_dir,
	output logic [COORD_W-1:0]      cur_x,
	output logic [COORD_W-1:0]      cur_y,
	output dir_e                    cur_dir,
	output logic                    off_grid,
	output logic                    at_goal,
	output logic                    dir_wrap
);

	always_ff @(posedge CLK or posedge RST) begin
		if (RST) begin
			cur_x    <= '0;
			cur_y    <= '0;
			off_grid <= 1'b0;
		end else if (init_pos) begin
			cur_x    <= '0;
			cur_y    <= '0;
			off_grid <= 1'b0;
		end else if (stack_pop) begin
			cur_x    <= pop_x;
			cur_y    <= pop_y;
			off_grid <= 1'b0;
		end else if (step) begin
			off_grid <= 1'b0;
			// leaving the grid keeps the position and raises the flag
			case (cur_dir)
				dir_north:
					if (cur_y == '0)
						off_grid <= 1'b1;
					else
						cur_y <= cur_y - 1'b1;
				dir_east:
					if (cur_x == COORD_W'(MAZE_DIM - 1))
						off_grid <= 1'b1;
					else
						cur_x <= cur_x + 1'b1;
				dir_south:
					if (cur_y == COORD_W'(MAZE_DIM - 1))
						off_grid <= 1'b1;
					else
						cur_y <= cur_y + 1'b1;
				dir_west:
					if (cur_x == '0)
						off_grid <= 1'b1;
					else
						cur_x <= cur_x - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			cur_dir <= dir_north;
		else if (init_dir)
			cur_dir <= dir_north;
		else if (stack_pop)
			cur_dir <= pop_dir;
		else if (dir_next)
			cur_dir <= dir_e'(cur_dir + 1'b1);
	end

	assign at_goal  = (cur_x == GOAL_X) && (cur_y == GOAL_Y) && !off_grid;
	assign dir_wrap = (cur_dir == dir_west);

endmodule

`default_nettype wire

//--- src/maze_memory.sv
`timescale 1ns/100ps
`default_nettype none

module maze_memory
	import maze_pkg::*;
(
	input  wire                     CLK,
	input  wire                     load_we,
	input  wire logic [COORD_W-1:0] load_x,
	input  wire logic [COORD_W-1:0] load_y,
	input  wire                     load_wall,
	input  wire                     mark_cell,
	input  wire logic [COORD_W-1:0] cur_x,
	input  wire logic [COORD_W-1:0] cur_y,
	output logic                    cell_wall
);

	logic                   cells [MAZE_DIM*MAZE_DIM];
	logic [CELL_ADDR_W-1:0] load_addr;
	logic [CELL_ADDR_W-1:0] cur_addr;

	assign load_addr = {load_y, load_x};
	assign cur_addr  = {cur_y, cur_x};

	// solver marking wins over the load port
	always_ff @(posedge CLK) begin
		if (mark_cell)
			cells[cur_addr] <= 1'b1;
		else if (load_we)
			cells[load_addr] <= load_wall;
	end

	assign cell_wall = cells[cur_addr];

	a_load_only_idle: assert property (@(posedge CLK) !(load_we && mark_cell));

endmodule

`default_nettype wire

//--- src/search_stack.sv
`timescale 1ns/100ps
`default_nettype none

module search_stack
	import maze_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     clear,
	input  wire                     push,
	input  wire                     pop,
	input  wire logic [COORD_W-1:0] push_x,
	input  wire logic [COORD_W-1:0] push_y,
	input  wire dir_e               push_dir,
	output logic [COORD_W-1:0]      top_x,
	output logic [COORD_W-1:0]      top_y,
	output dir_e                    top_dir,
	output logic                    stack_empty
);

	logic [2*COORD_W+DIR_W-1:0] entries [STORE_DEPTH];
	logic [2*COORD_W+DIR_W-1:0] top_entry;
	logic [PTR_W-1:0]           sp;
	logic [PTR_W-1:0]           top_idx;
	logic                       stack_full;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			sp <= '0;
		else if (clear)
			sp <= '0;
		else if (push)
			sp <= sp + 1'b1;
		else if (pop)
			sp <= sp - 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (push)
			entries[sp[PTR_W-2:0]] <= {push_x, push_y, push_dir};
	end

	// top entry is visible without waiting for a clock
	assign top_idx   = sp - 1'b1;
	assign top_entry = entries[top_idx[PTR_W-2:0]];
	assign top_x     = top_entry[2*COORD_W+DIR_W-1 -: COORD_W];
	assign top_y     = top_entry[COORD_W+DIR_W-1 -: COORD_W];
	assign top_dir   = dir_e'(top_entry[DIR_W-1:0]);

	assign stack_empty = (sp == '0);
	assign stack_full  = (sp == PTR_W'(STORE_DEPTH));

	a_no_push_full: assert property (@(posedge CLK) disable iff (RST) !(push && stack_full));
	a_no_pop_empty: assert property (@(posedge CLK) disable iff (RST) !(pop && stack_empty));

endmodule

`default_nettype wire

//--- src/path_list.sv
`timescale 1ns/100ps
`default_nettype none

module path_list
	import maze_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     clear,
	input  wire                     push,
	input  wire logic [COORD_W-1:0] push_x,
	input  wire logic [COORD_W-1:0] push_y,
	input  wire                     read_start,
	input  wire                     read_step,
	output logic [COORD_W-1:0]      path_x,
	output logic [COORD_W-1:0]      path_y,
	output logic                    read_last,
	output logic [PTR_W-1:0]        path_len
);

	logic [2*COORD_W-1:0] entries [STORE_DEPTH];
	logic [2*COORD_W-1:0] rd_entry;
	logic [PTR_W-1:0]     wr_ptr;
	logic [PTR_W-1:0]     rd_ptr;
	logic                 list_full;

	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			wr_ptr <= '0;
		else if (clear)
			wr_ptr <= '0;
		else if (push)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge CLK) begin
		if (push)
			entries[wr_ptr[PTR_W-2:0]] <= {push_x, push_y};
	end

	// goal sits at the bottom, so replay walks down from the top
	always_ff @(posedge CLK or posedge RST) begin
		if (RST)
			rd_ptr <= '0;
		else if (clear)
			rd_ptr <= '0;
		else if (read_start)
			rd_ptr <= wr_ptr - 1'b1;
		else if (read_step && !read_last)
			rd_ptr <= rd_ptr - 1'b1;
	end

	assign rd_entry  = entries[rd_ptr[PTR_W-2:0]];
	assign path_x    = rd_entry[2*COORD_W-1 -: COORD_W];
	assign path_y    = rd_entry[COORD_W-1:0];
	assign read_last = (rd_ptr == '0);
	assign path_len  = wr_ptr;
	assign list_full = (wr_ptr == PTR_W'(STORE_DEPTH));

	a_no_push_full: assert property (@(posedge CLK) disable iff (RST) !(push && list_full));

endmodule

`default_nettype wire

//--- src/maze_solver.sv
`timescale 1ns/100ps
`default_nettype none

module maze_solver
	import maze_pkg::*;
(
	input  wire                     CLK,
	input  wire                     RST,
	input  wire                     start,
	input  wire                     run,
	input  wire                     load_we,
	input  wire logic [COORD_W-1:0] load_x,
	input  wire logic [COORD_W-1:0] load_y,
	input  wire                     load_wall,
	output logic                    done,
	output logic                    fail,
	output logic                    path_valid,
	output logic [COORD_W-1:0]      path_x,
	output logic [COORD_W-1:0]      path_y,
	output logic                    path_last,
	output logic [PTR_W-1:0]        path_len
);

	logic               init_pos;
	logic               init_dir;
	logic               mark_cell;
	logic               stack_push;
	logic               step;
	logic               stack_pop;
	logic               dir_next;
	logic               list_push;
	logic               read_start;
	logic               read_step;
	logic               at_goal;
	logic               blocked;
	logic               dir_wrap;
	logic               stack_empty;
	logic               read_last;
	logic               off_grid;
	logic               cell_wall;
	logic [COORD_W-1:0] cur_x;
	logic [COORD_W-1:0] cur_y;
	dir_e               cur_dir;
	logic [COORD_W-1:0] top_x;
	logic [COORD_W-1:0] top_y;
	dir_e               top_dir;

	// off-grid steps and visited cells both count as walls
	assign blocked   = off_grid | cell_wall;
	assign path_last = path_valid & read_last;

	solver_controller u_solver_controller (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.at_goal(at_goal), .blocked(blocked), .dir_wrap(dir_wrap),
		.stack_empty(stack_empty), .read_last(read_last),
		.init_pos(init_pos), .init_dir(init_dir), .mark_cell(mark_cell),
		.stack_push(stack_push), .step(step), .stack_pop(stack_pop),
		.dir_next(dir_next), .list_push(list_push), .read_start(read_start),
		.read_step(read_step), .done(done), .fail(fail), .path_valid(path_valid)
	);

	position_datapath u_position_datapath (
		.CLK(CLK), .RST(RST), .init_pos(init_pos), .init_dir(init_dir),
		.step(step), .stack_pop(stack_pop), .dir_next(dir_next),
		.pop_x(top_x), .pop_y(top_y), .pop_dir(top_dir),
		.cur_x(cur_x), .cur_y(cur_y), .cur_dir(cur_dir),
		.off_grid(off_grid), .at_goal(at_goal), .dir_wrap(dir_wrap)
	);

	maze_memory u_maze_memory (
		.CLK(CLK), .load_we(load_we), .load_x(load_x), .load_y(load_y),
		.load_wall(load_wall), .mark_cell(mark_cell),
		.cur_x(cur_x), .cur_y(cur_y), .cell_wall(cell_wall)
	);

	search_stack u_search_stack (
		.CLK(CLK), .RST(RST), .clear(init_pos), .push(stack_push), .pop(stack_pop),
		.push_x(cur_x), .push_y(cur_y), .push_dir(cur_dir),
		.top_x(top_x), .top_y(top_y), .top_dir(top_dir), .stack_empty(stack_empty)
	);

	path_list u_path_list (
		.CLK(CLK), .RST(RST), .clear(init_pos), .push(list_push),
		.push_x(cur_x), .push_y(cur_y), .read_start(read_start), .read_step(read_step),
		.path_x(path_x), .path_y(path_y), .read_last(read_last), .path_len(path_len)
	);

endmodule

`default_nettype wire

//--- verif/maze_solver_tb.sv
`timescale 1ns/100ps
`default_nettype none

module maze_solver_tb
	import maze_pkg::*;
;

	localparam int CLK_PERIOD  = 20;
	localparam int NUM_CASES   = 7;
	localparam int CASE_CYCLES = 3000;
	localparam int EXP_FAIL    = 0;
	localparam int EXP_FOUND   = 1;
	localparam int EXP_MODEL   = 2;
	localparam int NUM_CELLS   = MAZE_DIM * MAZE_DIM;

	logic                CLK = 1'b0;
	logic                RST;
	logic                start;
	logic                run;
	logic                load_we;
	logic [COORD_W-1:0]  load_x;
	logic [COORD_W-1:0]  load_y;
	logic                load_wall;
	logic                done;
	logic                fail;
	logic                path_valid;
	logic [COORD_W-1:0]  path_x;
	logic [COORD_W-1:0]  path_y;
	logic                path_last;
	logic [PTR_W-1:0]    path_len;

	// one row per case where a set bit y*16+x means a wall
	logic [NUM_CELLS-1:0] case_maze   [NUM_CASES];
	bit                   case_random [NUM_CASES];
	int                   case_expect [NUM_CASES];

	int  exp_x [$];
	int  exp_y [$];
	int  seed;
	int  case_idx;
	bit  in_replay;

	maze_solver u_maze_solver (
		.CLK(CLK), .RST(RST), .start(start), .run(run),
		.load_we(load_we), .load_x(load_x), .load_y(load_y), .load_wall(load_wall),
		.done(done), .fail(fail), .path_valid(path_valid),
		.path_x(path_x), .path_y(path_y), .path_last(path_last), .path_len(path_len)
	);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("SIMULATION FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	// software depth-first search in north east south west order with goal before walls
	task automatic search_model(input logic [NUM_CELLS-1:0] maze, output bit found);
		bit seen [NUM_CELLS];
		int sx [NUM_CELLS];
		int sy [NUM_CELLS];
		int sd [NUM_CELLS];
		int sp;
		int cx;
		int cy;
		int d;
		int nx;
		int ny;
		bit searching;
		for (int i = 0; i < NUM_CELLS; i++)
			seen[i] = maze[i];
		exp_x.delete();
		exp_y.delete();
		found = 1'b0;
		sp = 0;
		cx = 0;
		cy = 0;
		d = 0;
		seen[0] = 1'b1;
		searching = 1'b1;
		while (searching) begin
			if (d == 4) begin
				if (sp == 0) begin
					searching = 1'b0;
				end else begin
					sp--;
					cx = sx[sp];
					cy = sy[sp];
					d = sd[sp] + 1;
				end
			end else begin
				nx = cx;
				ny = cy;
				case (d)
					0: ny = cy - 1;
					1: nx = cx + 1;
					2: ny = cy + 1;
					default: nx = cx - 1;
				endcase
				if (nx == GOAL_X && ny == GOAL_Y) begin
					for (int i = 0; i < sp; i++) begin
						exp_x.push_back(sx[i]);
						exp_y.push_back(sy[i]);
					end
					exp_x.push_back(cx);
					exp_y.push_back(cy);
					exp_x.push_back(nx);
					exp_y.push_back(ny);
					found = 1'b1;
					searching = 1'b0;
				end else if (nx < 0 || nx >= MAZE_DIM || ny < 0 || ny >= MAZE_DIM) begin
					d++;
				end else if (seen[ny * MAZE_DIM + nx]) begin
					d++;
				end else begin
					sx[sp] = cx;
					sy[sp] = cy;
					sd[sp] = d;
					sp++;
					cx = nx;
					cy = ny;
					seen[ny * MAZE_DIM + nx] = 1'b1;
					d = 0;
				end
			end
		end
	endtask

	task automatic make_random_maze(output logic [NUM_CELLS-1:0] maze);
		for (int i = 0; i < NUM_CELLS; i++)
			maze[i] = (($random(seed) & 7) < 3);
		// start and goal stay free
		maze[0] = 1'b0;
		maze[NUM_CELLS-1] = 1'b0;
	endtask

	task automatic apply_reset();
		@(negedge CLK);
		RST = 1'b1;
		repeat (16) @(negedge CLK);
		RST = 1'b0;
		@(negedge CLK);
		assert (!done && !fail && !path_valid && !path_last)
			else stop_on_error("outputs are not all low after reset");
	endtask

	task automatic load_maze(input logic [NUM_CELLS-1:0] maze);
		for (int i = 0; i < NUM_CELLS; i++) begin
			@(negedge CLK);
			load_we   = 1'b1;
			load_x    = COORD_W'(i % MAZE_DIM);
			load_y    = COORD_W'(i / MAZE_DIM);
			load_wall = maze[i];
		end
		@(negedge CLK);
		load_we = 1'b0;
	endtask

	task automatic start_search();
		@(negedge CLK);
		start = 1'b1;
		@(negedge CLK);
		start = 1'b0;
		while (!(done || fail))
			@(negedge CLK);
	endtask

	task automatic replay_path();
		int k;
		k = 0;
		@(negedge CLK);
		run = 1'b1;
		in_replay = 1'b1;
		@(negedge CLK);
		run = 1'b0;
		assert (path_valid) else stop_on_error("path_valid did not rise the cycle after run");
		while (path_valid) begin
			assert (k < exp_x.size()) else stop_on_error("replay is longer than the model path");
			assert (path_x == exp_x[k]) else stop_on_error($sformatf(
				"mismatch path_x: got %h expected %h (case %0d cell %0d)",
				path_x, exp_x[k], case_idx, k));
			assert (path_y == exp_y[k]) else stop_on_error($sformatf(
				"mismatch path_y: got %h expected %h (case %0d cell %0d)",
				path_y, exp_y[k], case_idx, k));
			assert (path_last == (k == exp_x.size() - 1)) else stop_on_error($sformatf(
				"mismatch path_last: got %h expected %h (case %0d cell %0d)",
				path_last, (k == exp_x.size() - 1), case_idx, k));
			k++;
			@(negedge CLK);
		end
		in_replay = 1'b0;
		assert (k == path_len) else stop_on_error($sformatf(
			"mismatch path_len: got %h with %h valid cycles", path_len, k));
		assert (done) else stop_on_error("solver did not return to done after the replay");
	endtask

	// a failed search must ignore run and stay in fail
	task automatic check_fail_hold();
		@(negedge CLK);
		run = 1'b1;
		@(negedge CLK);
		run = 1'b0;
		repeat (20) begin
			@(negedge CLK);
			assert (fail && !done && !path_valid)
				else stop_on_error("solver left fail or raised done or path_valid");
		end
	endtask

	always @(negedge CLK) begin
		assert (RST || !path_valid || in_replay)
			else stop_on_error("path_valid rose outside a replay");
	end

	initial begin
		#(CLK_PERIOD * CASE_CYCLES * NUM_CASES);
		$display("watchdog expired before all cases finished");
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	end

	initial begin
		logic [NUM_CELLS-1:0] maze;
		bit                   model_found;
		RST       = 1'b1;
		start     = 1'b0;
		run       = 1'b0;
		load_we   = 1'b0;
		load_x    = '0;
		load_y    = '0;
		load_wall = 1'b0;
		in_replay = 1'b0;
		seed      = 55;

		case_maze[0] = '0;
		case_random[0] = 1'b0;
		case_expect[0] = EXP_FOUND;
		// serpentine corridor
		case_maze[1] = {16'h7FFF, 16'h0000, 16'h7FFF, 16'h0000, 16'hFFFE, 16'h0000,
			16'h7FFF, 16'h0000, 16'hFFFE, 16'h0000, 16'h7FFF, 16'h0000,
			16'hFFFE, 16'h0000, 16'h7FFF, 16'h0000};
		case_random[1] = 1'b0;
		case_expect[1] = EXP_FOUND;
		// east branch dead-ends at (15,7) so the goal is reached down column 0
		case_maze[2] = {16'h0000, {7{16'hFFFE}}, {7{16'h7FFE}}, 16'h0000};
		case_random[2] = 1'b0;
		case_expect[2] = EXP_FOUND;
		// full wall down column 2
		case_maze[3] = {16{16'h0004}};
		case_random[3] = 1'b0;
		case_expect[3] = EXP_FAIL;
		for (int c = 4; c < NUM_CASES; c++) begin
			case_maze[c] = '0;
			case_random[c] = 1'b1;
			case_expect[c] = EXP_MODEL;
		end

		for (int c = 0; c < NUM_CASES; c++) begin
			case_idx = c;
			if (case_random[c])
				make_random_maze(maze);
			else
				maze = case_maze[c];
			search_model(maze, model_found);
			if (case_expect[c] != EXP_MODEL)
				assert (model_found == (case_expect[c] == EXP_FOUND))
					else stop_on_error($sformatf("model outcome disagrees with case %0d", c));
			apply_reset();
			load_maze(maze);
			start_search();
			assert (done == model_found) else stop_on_error($sformatf(
				"mismatch done: got %h expected %h (case %0d)", done, model_found, c));
			assert (fail == !model_found) else stop_on_error($sformatf(
				"mismatch fail: got %h expected %h (case %0d)", fail, !model_found, c));
			if (model_found) begin
				assert (path_len == exp_x.size()) else stop_on_error($sformatf(
					"mismatch path_len: got %h expected %h (case %0d)", path_len, exp_x.size(), c));
				replay_path();
				replay_path();
			end else begin
				check_fail_hold();
			end
		end

		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- maze_solver.f
src/maze_pkg.sv
src/solver_pkg.sv
src/solver_controller.sv
src/position_datapath.sv
src/maze_memory.sv
src/search_stack.sv
src/path_list.sv
src/maze_solver.sv
verif/maze_solver_tb.sv
